//--- source/scratch_tile_pkg.sv
package scratch_tile_pkg;

  localparam int unsigned ADDR_W = 16;  // APB and internal byte address
  localparam int unsigned DATA_W = 32;  // Data word

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [DATA_W/8-1:0] strb_t;  // One enable per byte

  // Address map
  localparam addr_t L1_BASE   = 16'h0000;  // Scratchpad window
  localparam addr_t L1_LIMIT  = 16'h0FFF;
  localparam addr_t DMA_BASE  = 16'h1000;  // DMA register window
  localparam addr_t DMA_LIMIT = 16'h101F;

  typedef enum logic [1:0] {
    TGT_SPM,   // L1 scratchpad
    TGT_DMA,   // DMA registers
    TGT_NONE   // Unmapped, answered with an error
  } target_e;

  typedef enum logic [4:0] {
    REG_SRC    = 5'h00,  // Source byte address
    REG_DST    = 5'h04,  // Destination byte address
    REG_LEN    = 5'h08,  // Length in words
    REG_CTRL   = 5'h0C,  // Bit0 start, bit1 clear done
    REG_STATUS = 5'h10   // Bit0 busy, bit1 done
  } dma_reg_e;

  typedef enum logic [1:0] {
    DMA_IDLE,
    DMA_READ,   // Read request pending
    DMA_WAIT,   // Waiting for read data
    DMA_WRITE   // Write request pending
  } dma_state_e;

  typedef enum logic [0:0] {
    INIT_EXT = 1'b0,  // External APB manager
    INIT_DMA = 1'b1
  } init_e;

endpackage

//--- source/tile_addr_decode.sv
module tile_addr_decode (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  scratch_tile_pkg::addr_t   paddr_i,
  input  scratch_tile_pkg::data_t   pwdata_i,
  input  scratch_tile_pkg::strb_t   pstrb_i,
  output scratch_tile_pkg::data_t   prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  output logic                      ext_req_o,
  output logic                      ext_we_o,
  output scratch_tile_pkg::addr_t   ext_addr_o,
  output scratch_tile_pkg::data_t   ext_wdata_o,
  output scratch_tile_pkg::strb_t   ext_be_o,
  input  logic                      ext_gnt_i,
  input  logic                      ext_rvalid_i,
  input  scratch_tile_pkg::data_t   ext_rdata_i,
  output logic                      reg_we_o,
  output logic                      reg_re_o,
  output scratch_tile_pkg::dma_reg_e reg_addr_o,
  output scratch_tile_pkg::data_t   reg_wdata_o,
  input  scratch_tile_pkg::data_t   reg_rdata_i
);

  scratch_tile_pkg::target_e tgt;
  logic                      access;    // APB access phase
  logic                      issued_q;  // Scratchpad request already granted

  always_comb begin
    if ((paddr_i >= scratch_tile_pkg::L1_BASE) && (paddr_i <= scratch_tile_pkg::L1_LIMIT)) begin
      tgt = scratch_tile_pkg::TGT_SPM;
    end else if ((paddr_i >= scratch_tile_pkg::DMA_BASE) &&
                 (paddr_i <= scratch_tile_pkg::DMA_LIMIT)) begin
      tgt = scratch_tile_pkg::TGT_DMA;
    end else begin
      tgt = scratch_tile_pkg::TGT_NONE;
    end
  end

  assign access = psel_i && penable_i;

  // Scratchpad side, one request per transfer
  assign ext_req_o   = access && (tgt == scratch_tile_pkg::TGT_SPM) && !issued_q;
  assign ext_we_o    = pwrite_i;
  assign ext_addr_o  = paddr_i;
  assign ext_wdata_o = pwdata_i;
  assign ext_be_o    = pwrite_i ? pstrb_i : '1;  // Reads fetch the full word

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      issued_q <= 1'b0;
    end else if (ext_rvalid_i) begin
      issued_q <= 1'b0;  // Transfer completes here
    end else if (ext_gnt_i) begin
      issued_q <= 1'b1;
    end
  end

  // Register side, answered in the first access cycle
  assign reg_we_o    = access && (tgt == scratch_tile_pkg::TGT_DMA) && pwrite_i;
  assign reg_re_o    = access && (tgt == scratch_tile_pkg::TGT_DMA) && !pwrite_i;
  assign reg_addr_o  = scratch_tile_pkg::dma_reg_e'(paddr_i[4:0]);  // Offset in window
  assign reg_wdata_o = pwdata_i;

  assign pready_o  = access && ((tgt == scratch_tile_pkg::TGT_SPM) ? ext_rvalid_i : 1'b1);
  assign pslverr_o = access && (tgt == scratch_tile_pkg::TGT_NONE);

  always_comb begin
    case (tgt)
      scratch_tile_pkg::TGT_SPM: prdata_o = ext_rdata_i;
      scratch_tile_pkg::TGT_DMA: prdata_o = reg_rdata_i;
      default:                   prdata_o = '0;
    endcase
  end

  // APB protocol from the manager side
  assert property (@(posedge clk_i) disable iff (!rst_ni) $rose(penable_i) |-> psel_i);

endmodule

//--- source/tile_dma.sv
module tile_dma (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       reg_we_i,
  input  logic                       reg_re_i,
  input  scratch_tile_pkg::dma_reg_e reg_addr_i,
  input  scratch_tile_pkg::data_t    reg_wdata_i,
  output scratch_tile_pkg::data_t    reg_rdata_o,
  output logic                       mem_req_o,
  output logic                       mem_we_o,
  output scratch_tile_pkg::addr_t    mem_addr_o,
  output scratch_tile_pkg::data_t    mem_wdata_o,
  input  logic                       mem_gnt_i,
  input  logic                       mem_rvalid_i,
  input  scratch_tile_pkg::data_t    mem_rdata_i,
  output logic                       busy_o,
  output logic                       done_o
);

  scratch_tile_pkg::dma_state_e state_q;
  scratch_tile_pkg::addr_t      src_q, dst_q, len_q;
  scratch_tile_pkg::addr_t      cnt_q;      // Words already copied
  scratch_tile_pkg::data_t      rd_data_q;  // Word in flight
  logic                         done_q;
  logic                         ctrl_wr;
  logic                         start;
  logic                         last;

  assign ctrl_wr = reg_we_i && (reg_addr_i == scratch_tile_pkg::REG_CTRL);
  assign start   = ctrl_wr && reg_wdata_i[0] && (state_q == scratch_tile_pkg::DMA_IDLE);
  assign last    = (cnt_q + 16'd1) == len_q;

  // Configuration only changes while idle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      src_q <= '0;
      dst_q <= '0;
      len_q <= '0;
    end else if (reg_we_i && (state_q == scratch_tile_pkg::DMA_IDLE)) begin
      case (reg_addr_i)
        scratch_tile_pkg::REG_SRC: src_q <= reg_wdata_i[scratch_tile_pkg::ADDR_W-1:0];
        scratch_tile_pkg::REG_DST: dst_q <= reg_wdata_i[scratch_tile_pkg::ADDR_W-1:0];
        scratch_tile_pkg::REG_LEN: len_q <= reg_wdata_i[scratch_tile_pkg::ADDR_W-1:0];
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= scratch_tile_pkg::DMA_IDLE;
      cnt_q   <= '0;
      done_q  <= 1'b0;
    end else begin
      if (ctrl_wr && reg_wdata_i[1]) begin
        done_q <= 1'b0;  // Clear request
      end
      case (state_q)
        scratch_tile_pkg::DMA_IDLE: begin
          if (start) begin
            cnt_q <= '0;
            if (len_q == '0) begin
              done_q <= 1'b1;  // Empty copy finishes at once
            end else begin
              done_q  <= 1'b0;
              state_q <= scratch_tile_pkg::DMA_READ;
            end
          end
        end
        scratch_tile_pkg::DMA_READ: begin
          if (mem_gnt_i) state_q <= scratch_tile_pkg::DMA_WAIT;
        end
        scratch_tile_pkg::DMA_WAIT: begin
          if (mem_rvalid_i) state_q <= scratch_tile_pkg::DMA_WRITE;
        end
        scratch_tile_pkg::DMA_WRITE: begin
          if (mem_gnt_i) begin
            cnt_q <= cnt_q + 16'd1;
            if (last) begin
              state_q <= scratch_tile_pkg::DMA_IDLE;
              done_q  <= 1'b1;
            end else begin
              state_q <= scratch_tile_pkg::DMA_READ;
            end
          end
        end
        default: state_q <= scratch_tile_pkg::DMA_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == scratch_tile_pkg::DMA_WAIT) && mem_rvalid_i) rd_data_q <= mem_rdata_i;
  end

  assign mem_req_o   = (state_q == scratch_tile_pkg::DMA_READ) ||
                       (state_q == scratch_tile_pkg::DMA_WRITE);
  assign mem_we_o    = state_q == scratch_tile_pkg::DMA_WRITE;
  assign mem_addr_o  = (mem_we_o ? dst_q : src_q) + (cnt_q << 2);  // Word stride
  assign mem_wdata_o = rd_data_q;
  assign busy_o      = state_q != scratch_tile_pkg::DMA_IDLE;
  assign done_o      = done_q;

  always_comb begin
    reg_rdata_o = '0;  // Unknown offsets read zero
    if (reg_re_i) begin
      case (reg_addr_i)
        scratch_tile_pkg::REG_SRC:    reg_rdata_o = scratch_tile_pkg::data_t'(src_q);
        scratch_tile_pkg::REG_DST:    reg_rdata_o = scratch_tile_pkg::data_t'(dst_q);
        scratch_tile_pkg::REG_LEN:    reg_rdata_o = scratch_tile_pkg::data_t'(len_q);
        scratch_tile_pkg::REG_STATUS: reg_rdata_o = scratch_tile_pkg::data_t'({done_q, busy_o});
        default: ;
      endcase
    end
  end

  // Request and its fields hold until the interconnect grants
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o && !mem_gnt_i) |=>
      (mem_req_o && $stable(mem_we_o) && $stable(mem_addr_o) && $stable(mem_wdata_o)));

endmodule

//--- source/tile_interconnect.sv
module tile_interconnect #(
  parameter int unsigned N_BANKS = 4,
  parameter int unsigned N_WORDS = 256
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic [1:0]                               init_req_i,  // Indexed by init_e
  input  logic [1:0]                               init_we_i,
  input  scratch_tile_pkg::addr_t [1:0]            init_addr_i,
  input  scratch_tile_pkg::data_t [1:0]            init_wdata_i,
  input  scratch_tile_pkg::strb_t [1:0]            init_be_i,
  output logic [1:0]                               init_gnt_o,
  output logic [1:0]                               init_rvalid_o,
  output scratch_tile_pkg::data_t [1:0]            init_rdata_o,
  output logic [N_BANKS-1:0]                       bank_req_o,
  output logic [N_BANKS-1:0]                       bank_we_o,
  output logic [N_BANKS-1:0][$clog2(N_WORDS)-1:0]  bank_idx_o,
  output scratch_tile_pkg::data_t [N_BANKS-1:0]    bank_wdata_o,
  output scratch_tile_pkg::strb_t [N_BANKS-1:0]    bank_be_o,
  input  scratch_tile_pkg::data_t [N_BANKS-1:0]    bank_rdata_i
);

  localparam int unsigned N_INIT = 2;
  localparam int unsigned BANK_W = $clog2(N_BANKS);
  localparam int unsigned IDX_W  = $clog2(N_WORDS);

  logic [N_INIT-1:0][BANK_W-1:0] bank_sel;  // Target bank per initiator
  logic [N_INIT-1:0][IDX_W-1:0]  word_idx;  // Row inside that bank
  logic [N_BANKS-1:0]            bank_win;  // Winning initiator per bank
  logic [N_INIT-1:0][BANK_W-1:0] rsel_q;    // Bank that returns rdata
  logic [N_INIT-1:0]             rvalid_q;

  always_comb begin
    for (int i = 0; i < N_INIT; i++) begin
      bank_sel[i] = init_addr_i[i][2 +: BANK_W];          // Word interleaving
      word_idx[i] = init_addr_i[i][2 + BANK_W +: IDX_W];
    end
  end

  for (genvar b = 0; b < N_BANKS; b++) begin : gen_bank
    logic [N_INIT-1:0] hit;
    logic              win;
    logic              last_q;  // Initiator granted last

    for (genvar i = 0; i < N_INIT; i++) begin : gen_hit
      assign hit[i] = init_req_i[i] && (bank_sel[i] == BANK_W'(b));
    end

    assign win         = (&hit) ? ~last_q : hit[scratch_tile_pkg::INIT_DMA];  // Round robin
    assign bank_win[b] = win;

    assign bank_req_o[b]   = |hit;
    assign bank_we_o[b]    = init_we_i[win];
    assign bank_idx_o[b]   = word_idx[win];
    assign bank_wdata_o[b] = init_wdata_i[win];
    assign bank_be_o[b]    = init_be_i[win];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        last_q <= scratch_tile_pkg::INIT_DMA;  // External port first
      end else if (|hit) begin
        last_q <= win;
      end
    end
  end

  for (genvar i = 0; i < N_INIT; i++) begin : gen_init
    assign init_gnt_o[i]   = init_req_i[i] && (bank_win[bank_sel[i]] == 1'(i));
    assign init_rvalid_o[i] = rvalid_q[i];
    assign init_rdata_o[i] = bank_rdata_i[rsel_q[i]];

    // A losing initiator gets its bank on the next cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (init_req_i[i] && !init_gnt_o[i]) |=> init_gnt_o[i]);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= '0;
    end else begin
      rvalid_q <= init_gnt_o;  // Response one cycle after grant
    end
  end

  always_ff @(posedge clk_i) begin
    rsel_q <= bank_sel;
  end

endmodule

//--- source/tile_l1_spm.sv
module tile_l1_spm #(
  parameter int unsigned N_BANKS = 4,
  parameter int unsigned N_WORDS = 256
) (
  input  logic                                    clk_i,
  input  logic [N_BANKS-1:0]                      bank_req_i,
  input  logic [N_BANKS-1:0]                      bank_we_i,
  input  logic [N_BANKS-1:0][$clog2(N_WORDS)-1:0] bank_idx_i,
  input  scratch_tile_pkg::data_t [N_BANKS-1:0]   bank_wdata_i,
  input  scratch_tile_pkg::strb_t [N_BANKS-1:0]   bank_be_i,
  output scratch_tile_pkg::data_t [N_BANKS-1:0]   bank_rdata_o
);

  localparam int unsigned N_BYTES = scratch_tile_pkg::DATA_W / 8;

  for (genvar b = 0; b < N_BANKS; b++) begin : gen_bank
    scratch_tile_pkg::data_t mem [N_WORDS];  // One SRAM macro per bank

    always_ff @(posedge clk_i) begin
      if (bank_req_i[b]) begin
        if (bank_we_i[b]) begin
          for (int k = 0; k < N_BYTES; k++) begin
            if (bank_be_i[b][k]) begin
              mem[bank_idx_i[b]][8*k +: 8] <= bank_wdata_i[b][8*k +: 8];
            end
          end
        end
        bank_rdata_o[b] <= mem[bank_idx_i[b]];  // Old data on a write
      end
    end
  end

endmodule

//--- source/scratch_tile.sv
module scratch_tile #(
  parameter int unsigned N_BANKS = 4,
  parameter int unsigned N_WORDS = 256
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  scratch_tile_pkg::addr_t paddr_i,
  input  scratch_tile_pkg::data_t pwdata_i,
  input  scratch_tile_pkg::strb_t pstrb_i,
  output scratch_tile_pkg::data_t prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  output logic                    dma_busy_o,
  output logic                    dma_done_o
);

  localparam int unsigned IDX_W = $clog2(N_WORDS);

  // Initiator ports, indexed by init_e
  logic [1:0]                          init_req, init_we, init_gnt, init_rvalid;
  scratch_tile_pkg::addr_t [1:0]       init_addr;
  scratch_tile_pkg::data_t [1:0]       init_wdata, init_rdata;
  scratch_tile_pkg::strb_t             ext_be;

  // DMA register access
  logic                                reg_we, reg_re;
  scratch_tile_pkg::dma_reg_e          reg_addr;
  scratch_tile_pkg::data_t             reg_wdata, reg_rdata;

  // Bank ports
  logic [N_BANKS-1:0]                  bank_req, bank_we;
  logic [N_BANKS-1:0][IDX_W-1:0]       bank_idx;
  scratch_tile_pkg::data_t [N_BANKS-1:0] bank_wdata, bank_rdata;
  scratch_tile_pkg::strb_t [N_BANKS-1:0] bank_be;

  tile_addr_decode i_addr_decode (
    .clk_i,
    .rst_ni,
    .psel_i,
    .penable_i,
    .pwrite_i,
    .paddr_i,
    .pwdata_i,
    .pstrb_i,
    .prdata_o,
    .pready_o,
    .pslverr_o,
    .ext_req_o    ( init_req[scratch_tile_pkg::INIT_EXT]    ),
    .ext_we_o     ( init_we[scratch_tile_pkg::INIT_EXT]     ),
    .ext_addr_o   ( init_addr[scratch_tile_pkg::INIT_EXT]   ),
    .ext_wdata_o  ( init_wdata[scratch_tile_pkg::INIT_EXT]  ),
    .ext_be_o     ( ext_be                                  ),
    .ext_gnt_i    ( init_gnt[scratch_tile_pkg::INIT_EXT]    ),
    .ext_rvalid_i ( init_rvalid[scratch_tile_pkg::INIT_EXT] ),
    .ext_rdata_i  ( init_rdata[scratch_tile_pkg::INIT_EXT]  ),
    .reg_we_o     ( reg_we                                  ),
    .reg_re_o     ( reg_re                                  ),
    .reg_addr_o   ( reg_addr                                ),
    .reg_wdata_o  ( reg_wdata                               ),
    .reg_rdata_i  ( reg_rdata                               )
  );

  tile_dma i_dma (
    .clk_i,
    .rst_ni,
    .reg_we_i     ( reg_we                                  ),
    .reg_re_i     ( reg_re                                  ),
    .reg_addr_i   ( reg_addr                                ),
    .reg_wdata_i  ( reg_wdata                               ),
    .reg_rdata_o  ( reg_rdata                               ),
    .mem_req_o    ( init_req[scratch_tile_pkg::INIT_DMA]    ),
    .mem_we_o     ( init_we[scratch_tile_pkg::INIT_DMA]     ),
    .mem_addr_o   ( init_addr[scratch_tile_pkg::INIT_DMA]   ),
    .mem_wdata_o  ( init_wdata[scratch_tile_pkg::INIT_DMA]  ),
    .mem_gnt_i    ( init_gnt[scratch_tile_pkg::INIT_DMA]    ),
    .mem_rvalid_i ( init_rvalid[scratch_tile_pkg::INIT_DMA] ),
    .mem_rdata_i  ( init_rdata[scratch_tile_pkg::INIT_DMA]  ),
    .busy_o       ( dma_busy_o                              ),
    .done_o       ( dma_done_o                              )
  );

  tile_interconnect #(
    .N_BANKS ( N_BANKS ),
    .N_WORDS ( N_WORDS )
  ) i_interconnect (
    .clk_i,
    .rst_ni,
    .init_req_i    ( init_req                               ),
    .init_we_i     ( init_we                                ),
    .init_addr_i   ( init_addr                              ),
    .init_wdata_i  ( init_wdata                             ),
    .init_be_i     ( {4'hF, ext_be}                         ),  // DMA moves whole words
    .init_gnt_o    ( init_gnt                               ),
    .init_rvalid_o ( init_rvalid                            ),
    .init_rdata_o  ( init_rdata                             ),
    .bank_req_o    ( bank_req                               ),
    .bank_we_o     ( bank_we                                ),
    .bank_idx_o    ( bank_idx                               ),
    .bank_wdata_o  ( bank_wdata                             ),
    .bank_be_o     ( bank_be                                ),
    .bank_rdata_i  ( bank_rdata                             )
  );

  tile_l1_spm #(
    .N_BANKS ( N_BANKS ),
    .N_WORDS ( N_WORDS )
  ) i_l1_spm (
    .clk_i,
    .bank_req_i   ( bank_req   ),
    .bank_we_i    ( bank_we    ),
    .bank_idx_i   ( bank_idx   ),
    .bank_wdata_i ( bank_wdata ),
    .bank_be_i    ( bank_be    ),
    .bank_rdata_o ( bank_rdata )
  );

endmodule

//--- dv/tb_clk_rst.sv
module tb_clk_rst #(
  parameter int unsigned PERIOD     = 8,  // Clock period in time units
  parameter int unsigned RST_CYCLES = 2   // Rising edges with reset held
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD / 2) clk_o = ~clk_o;  // Free running
    end
  end

  initial begin
    rst_no = 1'b0;  // Asserted from time zero
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;  // Released on a falling edge like all stimulus
  end

endmodule

//--- dv/tb_scratch_tile.sv
module tb_scratch_tile;

  localparam int unsigned N_BANKS      = 4;
  localparam int unsigned N_WORDS      = 256;
  localparam int unsigned CYC_PER_STEP = 200;  // Watchdog budget per table entry
  localparam int unsigned CYC_PER_WORD = 20;   // Extra budget per copied word

  typedef enum logic [1:0] {
    OP_WR,        // APB write
    OP_RD,        // APB read
    OP_FLAGS,     // Check busy and done, data[0] busy, data[1] done
    OP_WAIT_DONE  // Wait for done, then busy must be low
  } op_e;

  typedef struct {
    op_e                     op;
    scratch_tile_pkg::addr_t addr;
    scratch_tile_pkg::data_t data;
    scratch_tile_pkg::strb_t strb;
    scratch_tile_pkg::data_t exp_data;
    logic                    exp_err;
  } step_t;

  logic                    clk, rst_n;
  logic                    psel, penable, pwrite;
  scratch_tile_pkg::addr_t paddr;
  scratch_tile_pkg::data_t pwdata, prdata;
  scratch_tile_pkg::strb_t pstrb;
  logic                    pready, pslverr, dma_busy, dma_done;

  step_t                   steps[$];        // Stimulus table
  scratch_tile_pkg::data_t ref_mem [1024];  // Expected scratchpad, one entry per word
  scratch_tile_pkg::addr_t mdl_src, mdl_dst;
  int unsigned             mdl_len;
  int unsigned             dma_words;       // Words moved by all copies

  tb_clk_rst #(.PERIOD(8), .RST_CYCLES(2)) i_clk_rst (.clk_o(clk), .rst_no(rst_n));

  scratch_tile #(.N_BANKS(N_BANKS), .N_WORDS(N_WORDS)) i_scratch_tile (
    .clk_i(clk), .rst_ni(rst_n), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
    .paddr_i(paddr), .pwdata_i(pwdata), .pstrb_i(pstrb), .prdata_o(prdata),
    .pready_o(pready), .pslverr_o(pslverr), .dma_busy_o(dma_busy), .dma_done_o(dma_done)
  );

  function automatic void push_step(op_e op, scratch_tile_pkg::addr_t addr,
                                    scratch_tile_pkg::data_t data, scratch_tile_pkg::strb_t strb,
                                    scratch_tile_pkg::data_t exp_data, logic exp_err);
    step_t s;
    s.op       = op;
    s.addr     = addr;
    s.data     = data;
    s.strb     = strb;
    s.exp_data = exp_data;
    s.exp_err  = exp_err;
    steps.push_back(s);
  endfunction

  function automatic void spm_write(scratch_tile_pkg::addr_t addr, scratch_tile_pkg::data_t data,
                                    scratch_tile_pkg::strb_t strb);
    for (int k = 0; k < 4; k++) begin
      if (strb[k]) ref_mem[addr[11:2]][8*k +: 8] = data[8*k +: 8];  // Enabled bytes only
    end
    push_step(OP_WR, addr, data, strb, '0, 1'b0);
  endfunction

  function automatic void spm_read(scratch_tile_pkg::addr_t addr);
    push_step(OP_RD, addr, '0, 4'h0, ref_mem[addr[11:2]], 1'b0);
  endfunction

  function automatic void fill(scratch_tile_pkg::addr_t base, int unsigned n);
    for (int unsigned i = 0; i < n; i++) begin
      spm_write(scratch_tile_pkg::addr_t'(base + 4 * i), $urandom, 4'hF);
    end
  endfunction

  function automatic void read_range(scratch_tile_pkg::addr_t base, int unsigned n);
    for (int unsigned i = 0; i < n; i++) begin
      spm_read(scratch_tile_pkg::addr_t'(base + 4 * i));
    end
  endfunction

  function automatic void reg_write(scratch_tile_pkg::dma_reg_e off, scratch_tile_pkg::data_t data);
    push_step(OP_WR, scratch_tile_pkg::DMA_BASE + scratch_tile_pkg::addr_t'(off), data, 4'hF,
              '0, 1'b0);
  endfunction

  function automatic void reg_read(scratch_tile_pkg::dma_reg_e off, scratch_tile_pkg::data_t exp);
    push_step(OP_RD, scratch_tile_pkg::DMA_BASE + scratch_tile_pkg::addr_t'(off), '0, 4'h0,
              exp, 1'b0);
  endfunction

  function automatic void bad_access(scratch_tile_pkg::addr_t addr);
    push_step(OP_WR, addr, 32'hDEAD_BEEF, 4'hF, '0, 1'b1);
    push_step(OP_RD, addr, '0, 4'h0, '0, 1'b1);  // Error reads return zero
  endfunction

  function automatic void dma_setup(scratch_tile_pkg::addr_t src, scratch_tile_pkg::addr_t dst,
                                    int unsigned len);
    mdl_src = src;
    mdl_dst = dst;
    mdl_len = len;
    reg_write(scratch_tile_pkg::REG_SRC, scratch_tile_pkg::data_t'(src));
    reg_write(scratch_tile_pkg::REG_DST, scratch_tile_pkg::data_t'(dst));
    reg_write(scratch_tile_pkg::REG_LEN, scratch_tile_pkg::data_t'(len));
    reg_read(scratch_tile_pkg::REG_SRC, scratch_tile_pkg::data_t'(src));
    reg_read(scratch_tile_pkg::REG_DST, scratch_tile_pkg::data_t'(dst));
    reg_read(scratch_tile_pkg::REG_LEN, scratch_tile_pkg::data_t'(len));
  endfunction

  function automatic void dma_start();
    int unsigned ws;
    int unsigned wd;
    ws = int'(mdl_src) / 4;
    wd = int'(mdl_dst) / 4;
    reg_write(scratch_tile_pkg::REG_CTRL, 32'h1);
    for (int unsigned i = 0; i < mdl_len; i++) begin
      ref_mem[wd + i] = ref_mem[ws + i];  // Forward word copy
    end
    dma_words += mdl_len;
  endfunction

  function automatic void expect_flags(logic busy, logic done);
    push_step(OP_FLAGS, '0, scratch_tile_pkg::data_t'({done, busy}), 4'h0, '0, 1'b0);
  endfunction

  function automatic void build_table();
    // Reset state
    expect_flags(1'b0, 1'b0);
    reg_read(scratch_tile_pkg::REG_SRC, '0);
    reg_read(scratch_tile_pkg::REG_DST, '0);
    reg_read(scratch_tile_pkg::REG_LEN, '0);
    reg_read(scratch_tile_pkg::REG_STATUS, '0);
    push_step(OP_RD, 16'h1014, '0, 4'h0, '0, 1'b0);  // Unused offset in the window
    // Every bank twice, plus both window ends
    fill(16'h0100, 8);
    read_range(16'h0100, 8);
    spm_write(16'h0000, $urandom, 4'hF);
    spm_write(16'h0FFC, $urandom, 4'hF);
    spm_read(16'h0000);
    spm_read(16'h0FFC);
    spm_write(16'h0104, $urandom, 4'b0101);  // Partial strobes
    spm_write(16'h0108, $urandom, 4'b1000);
    spm_write(16'h010C, $urandom, 4'b0010);
    read_range(16'h0104, 3);
    bad_access(16'h1020);
    bad_access(16'h2000);
    bad_access(16'hFFFC);
    // Plain copy, word after the destination is a sentinel
    fill(16'h0200, 12);
    fill(16'h0400, 13);
    dma_setup(16'h0200, 16'h0400, 12);
    dma_start();
    expect_flags(1'b1, 1'b0);
    push_step(OP_WAIT_DONE, '0, '0, 4'h0, '0, 1'b0);
    reg_read(scratch_tile_pkg::REG_STATUS, 32'h2);
    read_range(16'h0400, 13);
    reg_write(scratch_tile_pkg::REG_CTRL, 32'h2);
    expect_flags(1'b0, 1'b0);
    reg_read(scratch_tile_pkg::REG_STATUS, '0);
    // Copy with external traffic competing for the banks
    fill(16'h0800, 24);
    fill(16'h0A00, 25);
    dma_setup(16'h0800, 16'h0A00, 24);
    dma_start();
    for (int unsigned i = 0; i < 12; i++) begin
      spm_write(scratch_tile_pkg::addr_t'(16'h0C00 + 4 * i), $urandom, 4'hF);
      spm_read(scratch_tile_pkg::addr_t'(16'h0C00 + 4 * i));
    end
    push_step(OP_WAIT_DONE, '0, '0, 4'h0, '0, 1'b0);
    read_range(16'h0A00, 25);
    read_range(16'h0C00, 12);
    reg_write(scratch_tile_pkg::REG_CTRL, 32'h2);
    // Empty copy
    fill(16'h0380, 2);
    dma_setup(16'h0300, 16'h0380, 0);
    dma_start();
    expect_flags(1'b0, 1'b1);  // Done right after the start write
    reg_read(scratch_tile_pkg::REG_STATUS, 32'h2);
    read_range(16'h0380, 2);
    reg_write(scratch_tile_pkg::REG_CTRL, 32'h2);
    expect_flags(1'b0, 1'b0);
  endfunction

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "Stopped at the first failing check");
  endtask

  task automatic check_data(input string name, input scratch_tile_pkg::data_t exp,
                            input scratch_tile_pkg::data_t act);
    if (act !== exp) begin
      stop_with_failure($sformatf("ERROR at %0t: %s expected 0x%08h, got 0x%08h",
                                  $time, name, exp, act));
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_failure($sformatf("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_failure($sformatf("ERROR at %0t: %s expected %b, got %b", $time, name, exp, act));
    end
  endtask

  task automatic watchdog(input int unsigned cycles);
    repeat (cycles) @(posedge clk);
    stop_with_failure($sformatf("Timeout after %0d cycles, the run hung", cycles));
  endtask

  // Setup on one falling edge, access from the next, sampled 1 unit after the edge
  task automatic apb_transfer(input logic write, input scratch_tile_pkg::addr_t addr,
                              input scratch_tile_pkg::data_t data,
                              input scratch_tile_pkg::strb_t strb,
                              output scratch_tile_pkg::data_t rdata, output logic err,
                              output logic ready_first);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = data;
    pstrb   = write ? strb : 4'h0;
    @(negedge clk);
    penable = 1'b1;
    #1;
    ready_first = pready;  // Ready in the first access cycle
    while (!pready) begin  // Back-pressure from the tile
      @(negedge clk);
      #1;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);  // Transfer ended on the rising edge before
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic run_step(input int idx);
    step_t                   s;
    scratch_tile_pkg::data_t rdata;
    logic                    err;
    logic                    rdy_first;
    s = steps[idx];
    case (s.op)
      OP_WR: begin
        apb_transfer(1'b1, s.addr, s.data, s.strb, rdata, err, rdy_first);
        // Registers and unmapped addresses answer at once, the scratchpad a cycle later
        check_flag($sformatf("pready_o step %0d", idx),
                   s.addr > scratch_tile_pkg::L1_LIMIT, rdy_first);
        check_err($sformatf("pslverr_o step %0d", idx), s.exp_err, err);
      end
      OP_RD: begin
        apb_transfer(1'b0, s.addr, '0, 4'h0, rdata, err, rdy_first);
        check_flag($sformatf("pready_o step %0d", idx),
                   s.addr > scratch_tile_pkg::L1_LIMIT, rdy_first);
        check_err($sformatf("pslverr_o step %0d", idx), s.exp_err, err);
        check_data($sformatf("prdata_o step %0d", idx), s.exp_data, rdata);
      end
      OP_FLAGS: begin
        #1;
        check_flag($sformatf("dma_busy_o step %0d", idx), s.data[0], dma_busy);
        check_flag($sformatf("dma_done_o step %0d", idx), s.data[1], dma_done);
      end
      default: begin
        #1;
        while (!dma_done) begin  // Copy length decides the wait
          @(negedge clk);
          #1;
        end
        check_flag($sformatf("dma_busy_o step %0d", idx), 1'b0, dma_busy);
      end
    endcase
  endtask

  initial begin
    int unsigned limit;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    pstrb     = '0;
    dma_words = 0;
    void'($urandom(9));  // One seed for all random data
    build_table();
    limit = steps.size() * CYC_PER_STEP + dma_words * CYC_PER_WORD;
    fork
      watchdog(limit);
    join_none
    wait (rst_n === 1'b1);
    foreach (steps[i]) begin
      run_step(i);
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- build.f
source/scratch_tile_pkg.sv
source/tile_addr_decode.sv
source/tile_dma.sv
source/tile_interconnect.sv
source/tile_l1_spm.sv
source/scratch_tile.sv
dv/tb_clk_rst.sv
dv/tb_scratch_tile.sv

//--- Makefile
# Verilator flow for the scratch tile testbench

TOP       ?= tb_scratch_tile
SEED      ?= 9
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FILELIST  := build.f
SRCS      := $(shell grep -v '^+' $(FILELIST))
BIN       := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when the file list or a source changes
$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides pass or fail
run: $(BIN)
	./$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "ALL CHECKS PASSED" $(LOG); then \
	  echo "Simulation passed"; \
	else \
	  echo "Simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
